//--- list.f
rtl/coh_pkg.sv
rtl/line_state_if.sv
rtl/snoop_if.sv
rtl/line_state_array.sv
rtl/bus_req_issuer.sv
rtl/snoop_responder.sv
rtl/coherence_ctrl.sv
rtl/icache_coherence.sv
verification/icache_coherence_asserts.sv
verification/icache_coherence_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_coherence_tb -f list.f \
  && ./obj_dir/Vicache_coherence_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- verification/icache_coherence_tb.sv
`timescale 1ns/1ps

module icache_coherence_tb
  import coh_pkg::*;
();

  localparam int WAYS     = 4;
  localparam int SETS     = 16;
  localparam int CACHE_ID = 0;
  localparam int MEM_ID   = 15;
  localparam int TIMEOUT  = 20;

  // Selectors for the single-bit outputs that the wait loops watch
  localparam int SIG_DFP_RESP = 0;
  localparam int SIG_REQ      = 1;
  localparam int SIG_RESP_REQ = 2;
  localparam int SIG_INV      = 3;

  logic            clk;
  logic            rst;
  addr_t           dfp_addr;
  logic            dfp_read;
  logic            cache_read_request;
  line_t           dfp_rdata;
  logic            dfp_resp;
  logic [WAYS-1:0] cache_hit_vector;
  logic [WAYS-1:0] bus_hit_vector;
  logic [WAYS-1:0] evict_candidate;
  line_t           bus_rdata;
  logic            req_msg_valid;
  cache_id_t       req_msg_src;
  addr_t           req_msg_addr;
  bus_cmd_t        req_msg_cmd;
  logic            req_bus_req;
  cache_id_t       req_tx_src;
  addr_t           req_tx_addr;
  bus_cmd_t        req_tx_cmd;
  logic            req_bus_busy;
  logic            resp_msg_valid;
  cache_id_t       resp_msg_src;
  cache_id_t       resp_msg_dst;
  logic [1:0]      resp_msg_way;
  resp_kind_t      resp_msg_kind;
  line_t           resp_msg_data;
  logic            resp_bus_req;
  cache_id_t       resp_tx_dst;
  logic [1:0]      resp_tx_way;
  logic            resp_tx_mem;
  addr_t           resp_tx_addr;
  line_t           resp_tx_data;
  resp_kind_t      resp_tx_kind;
  logic            invalidate_req;
  logic            invalidate_resp;

  int        errors = 0;
  cache_id_t other;

  icache_coherence #(
    .WAYS    (WAYS),
    .SETS    (SETS),
    .CACHE_ID(CACHE_ID),
    .MEM_ID  (MEM_ID)
  ) icache_coherence_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < LINE_BITS / 32; i++) begin
      l[i*32 +: 32] = $urandom;
    end
    return l;
  endfunction

  function automatic logic out_bit(input int sel);
    case (sel)
      SIG_DFP_RESP: return dfp_resp;
      SIG_REQ:      return req_bus_req;
      SIG_RESP_REQ: return resp_bus_req;
      default:      return invalidate_resp;
    endcase
  endfunction

  function automatic string sig_name(input int sel);
    case (sel)
      SIG_DFP_RESP: return "dfp_resp";
      SIG_REQ:      return "req_bus_req";
      SIG_RESP_REQ: return "resp_bus_req";
      default:      return "invalidate_resp";
    endcase
  endfunction

  task automatic check_value(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic wait_for_level(input int sel, input logic level);
    for (int n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (out_bit(sel) === level) begin
        return;
      end
    end
    errors++;
    $display("Timed out at %0t waiting for %s to become %0b", $time, sig_name(sel), level);
  endtask

  // Bounded watch over a window in which the output must stay low
  task automatic expect_quiet(input int sel, input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (out_bit(sel) !== 1'b0) begin
        errors++;
        $display("ERROR at %0t: %s = %0b, expected 0", $time, sig_name(sel), out_bit(sel));
      end
    end
  endtask

  task automatic cpu_read(input addr_t addr, input logic [3:0] hit, input logic [3:0] evict);
    @(posedge clk);
    dfp_addr           <= addr;
    dfp_read           <= 1'b1;
    cache_read_request <= 1'b1;
    cache_hit_vector   <= hit;
    evict_candidate    <= evict;
    @(posedge clk);
    dfp_read           <= 1'b0;
    cache_read_request <= 1'b0;
    cache_hit_vector   <= '0;
    evict_candidate    <= '0;
  endtask

  task automatic request_bus_msg(input cache_id_t src, input addr_t addr, input bus_cmd_t cmd,
                                 input logic [3:0] bus_hit);
    @(posedge clk);
    req_msg_valid  <= 1'b1;
    req_msg_src    <= src;
    req_msg_addr   <= addr;
    req_msg_cmd    <= cmd;
    bus_hit_vector <= bus_hit;
    @(posedge clk);
    req_msg_valid  <= 1'b0;
    req_msg_cmd    <= NONE;
    bus_hit_vector <= '0;
  endtask

  task automatic response_bus_msg(input cache_id_t src, input cache_id_t dst,
                                  input logic [1:0] way, input resp_kind_t kind,
                                  input line_t data);
    @(posedge clk);
    resp_msg_valid <= 1'b1;
    resp_msg_src   <= src;
    resp_msg_dst   <= dst;
    resp_msg_way   <= way;
    resp_msg_kind  <= kind;
    resp_msg_data  <= data;
    @(posedge clk);
    resp_msg_valid <= 1'b0;
  endtask

  task automatic back_invalidate(input addr_t addr, input logic [3:0] hit);
    @(posedge clk);
    dfp_addr         <= addr;
    invalidate_req   <= 1'b1;
    cache_hit_vector <= hit;
    @(posedge clk);
    invalidate_req   <= 1'b0;
    cache_hit_vector <= '0;
  endtask

  // Miss, own GetS echoed by the bus, then a fill from memory
  task automatic load_miss(input addr_t addr, input logic [1:0] way, input resp_kind_t kind);
    line_t data;
    data = random_line();
    cpu_read(addr, '0, 4'(1) << way);
    wait_for_level(SIG_REQ, 1'b1);
    check_value("req_tx_cmd", line_t'(req_tx_cmd), line_t'(GETS));
    check_value("req_tx_addr", line_t'(req_tx_addr), line_t'(addr));
    check_value("req_tx_src", line_t'(req_tx_src), line_t'(CACHE_ID));
    request_bus_msg(cache_id_t'(CACHE_ID), addr, GETS, '0);
    wait_for_level(SIG_REQ, 1'b0);
    check_value("req_bus_busy", line_t'(req_bus_busy), line_t'(1'b1));
    response_bus_msg(cache_id_t'(MEM_ID), cache_id_t'(CACHE_ID), way, kind, data);
    wait_for_level(SIG_DFP_RESP, 1'b1);
    check_value("dfp_rdata", dfp_rdata, data);
    check_value("req_bus_busy", line_t'(req_bus_busy), '0);
  endtask

  // Another cache snoops an E line, then our response is seen on the bus
  task automatic snoop_e_line(input addr_t addr, input logic [1:0] way, input bus_cmd_t cmd,
                              input logic exp_mem);
    line_t data;
    data = random_line();
    @(posedge clk);
    bus_rdata <= data;
    request_bus_msg(other, addr, cmd, 4'(1) << way);
    wait_for_level(SIG_RESP_REQ, 1'b1);
    check_value("resp_tx_dst", line_t'(resp_tx_dst), line_t'(other));
    check_value("resp_tx_mem", line_t'(resp_tx_mem), line_t'(exp_mem));
    check_value("resp_tx_data", resp_tx_data, data);
    check_value("resp_tx_way", line_t'(resp_tx_way), line_t'(way));
    check_value("resp_tx_addr", line_t'(resp_tx_addr), line_t'(addr));
    check_value("resp_tx_kind", line_t'(resp_tx_kind), line_t'(DATA));
    check_value("req_bus_busy", line_t'(req_bus_busy), line_t'(1'b1));
    response_bus_msg(cache_id_t'(CACHE_ID), other, way, DATA, data);
    wait_for_level(SIG_RESP_REQ, 1'b0);
    check_value("req_bus_busy", line_t'(req_bus_busy), '0);
  endtask

  task automatic after_reset_state();
    @(negedge clk);
    check_value("dfp_resp", line_t'(dfp_resp), '0);
    check_value("dfp_rdata", dfp_rdata, '0);
    check_value("req_bus_req", line_t'(req_bus_req), '0);
    check_value("req_tx_src", line_t'(req_tx_src), '0);
    check_value("req_tx_addr", line_t'(req_tx_addr), '0);
    check_value("req_tx_cmd", line_t'(req_tx_cmd), '0);
    check_value("req_bus_busy", line_t'(req_bus_busy), '0);
    check_value("resp_bus_req", line_t'(resp_bus_req), '0);
    check_value("resp_tx_dst", line_t'(resp_tx_dst), '0);
    check_value("resp_tx_way", line_t'(resp_tx_way), '0);
    check_value("resp_tx_mem", line_t'(resp_tx_mem), '0);
    check_value("resp_tx_addr", line_t'(resp_tx_addr), '0);
    check_value("resp_tx_data", resp_tx_data, '0);
    check_value("resp_tx_kind", line_t'(resp_tx_kind), '0);
    check_value("invalidate_resp", line_t'(invalidate_resp), '0);
    // Every line is I, so no way can hit
    for (int w = 0; w < WAYS; w++) begin
      cpu_read(addr_t'($urandom), 4'(1) << w, '0);
      expect_quiet(SIG_DFP_RESP, 3);
    end
  endtask

  task automatic data_fill(input addr_t addr);
    load_miss(addr, 2'd0, DATA);
    cpu_read(addr, 4'b0001, '0);
    wait_for_level(SIG_DFP_RESP, 1'b1);
  endtask

  task automatic exclusive_then_gets(input addr_t addr);
    load_miss(addr, 2'd1, EXCLUSIVE);
    snoop_e_line(addr, 2'd1, GETS, 1'b1);
    // Line is S now, so a GetM drops it silently
    request_bus_msg(other, addr, GETM, 4'b0010);
    expect_quiet(SIG_RESP_REQ, 3);
    cpu_read(addr, 4'b0010, '0);
    expect_quiet(SIG_DFP_RESP, 3);
  endtask

  task automatic getm_to_exclusive(input addr_t addr);
    load_miss(addr, 2'd2, EXCLUSIVE);
    snoop_e_line(addr, 2'd2, GETM, 1'b0);
    cpu_read(addr, 4'b0100, '0);
    expect_quiet(SIG_DFP_RESP, 3);
  endtask

  task automatic back_invalidation(input addr_t addr);
    load_miss(addr, 2'd3, DATA);
    back_invalidate(addr, 4'b1000);
    wait_for_level(SIG_INV, 1'b1);
    cpu_read(addr, 4'b1000, '0);
    expect_quiet(SIG_DFP_RESP, 3);
  endtask

  initial begin
    void'($urandom(71));
    rst                <= 1'b1;
    dfp_addr           <= '0;
    dfp_read           <= 1'b0;
    cache_read_request <= 1'b0;
    cache_hit_vector   <= '0;
    bus_hit_vector     <= '0;
    evict_candidate    <= '0;
    bus_rdata          <= '0;
    req_msg_valid      <= 1'b0;
    req_msg_src        <= '0;
    req_msg_addr       <= '0;
    req_msg_cmd        <= NONE;
    resp_msg_valid     <= 1'b0;
    resp_msg_src       <= '0;
    resp_msg_dst       <= '0;
    resp_msg_way       <= '0;
    resp_msg_kind      <= DATA;
    resp_msg_data      <= '0;
    invalidate_req     <= 1'b0;
    // Any node except this cache and memory
    other = cache_id_t'(1 + $urandom % 14);
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    after_reset_state();
    data_fill(addr_t'($urandom));
    exclusive_then_gets(addr_t'($urandom));
    getm_to_exclusive(addr_t'($urandom));
    back_invalidation(addr_t'($urandom));

    repeat (2) @(posedge clk);
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (2000) @(posedge clk);
    $display("Simulation did not finish within the cycle limit");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- verification/icache_coherence_asserts.sv
`timescale 1ns/1ps

module icache_coherence_asserts (
  input logic clk,
  input logic rst,
  input logic issue_gets,
  input logic req_bus_busy,
  input logic dfp_resp,
  input logic invalidate_resp
);

  // req_bus_req rises the cycle after issue_gets, and the bus must not be held then
  req_not_under_busy: assert property (@(posedge clk) disable iff (rst)
    issue_gets |=> !req_bus_busy)
    else $error("req_bus_req rose while req_bus_busy was high");

  dfp_resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
    dfp_resp |=> !dfp_resp)
    else $error("dfp_resp stayed high for more than one cycle");

  inv_resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
    invalidate_resp |=> !invalidate_resp)
    else $error("invalidate_resp stayed high for more than one cycle");

endmodule

bind coherence_ctrl icache_coherence_asserts asserts_i (
  .clk            (clk),
  .rst            (rst),
  .issue_gets     (issue_gets),
  .req_bus_busy   (req_bus_busy),
  .dfp_resp       (dfp_resp),
  .invalidate_resp(invalidate_resp)
);

//--- rtl/icache_coherence.sv
`timescale 1ns/1ps

module icache_coherence
  import coh_pkg::*;
#(
  parameter int WAYS     = 4,
  parameter int SETS     = 16,
  parameter int CACHE_ID = 0,
  parameter int MEM_ID   = 15
) (
  input  logic                    clk,
  input  logic                    rst,
  // Processor side
  input  addr_t                   dfp_addr,
  input  logic                    dfp_read,
  input  logic                    cache_read_request,
  output line_t                   dfp_rdata,
  output logic                    dfp_resp,
  // Tag store and data array
  input  logic [WAYS-1:0]         cache_hit_vector,
  input  logic [WAYS-1:0]         bus_hit_vector,
  input  logic [WAYS-1:0]         evict_candidate,
  input  line_t                   bus_rdata,
  // Request bus
  input  logic                    req_msg_valid,
  input  cache_id_t               req_msg_src,
  input  addr_t                   req_msg_addr,
  input  bus_cmd_t                req_msg_cmd,
  output logic                    req_bus_req,
  output cache_id_t               req_tx_src,
  output addr_t                   req_tx_addr,
  output bus_cmd_t                req_tx_cmd,
  output logic                    req_bus_busy,
  // Response bus
  input  logic                    resp_msg_valid,
  input  cache_id_t               resp_msg_src,
  input  cache_id_t               resp_msg_dst,
  input  logic [$clog2(WAYS)-1:0] resp_msg_way,
  input  resp_kind_t              resp_msg_kind,
  input  line_t                   resp_msg_data,
  output logic                    resp_bus_req,
  output cache_id_t               resp_tx_dst,
  output logic [$clog2(WAYS)-1:0] resp_tx_way,
  output logic                    resp_tx_mem,
  output addr_t                   resp_tx_addr,
  output line_t                   resp_tx_data,
  output resp_kind_t              resp_tx_kind,
  // Inclusion with the outer cache
  input  logic                    invalidate_req,
  output logic                    invalidate_resp
);

  logic issue_gets;
  logic own_gets_seen;

  line_state_if #(.WAYS(WAYS), .SETS(SETS)) lsif ();
  snoop_if #(.WAYS(WAYS)) snp ();

  coherence_ctrl #(
    .WAYS    (WAYS),
    .SETS    (SETS),
    .CACHE_ID(CACHE_ID),
    .MEM_ID  (MEM_ID)
  ) ctrl_i (
    .clk               (clk),
    .rst               (rst),
    .dfp_addr          (dfp_addr),
    .dfp_read          (dfp_read),
    .cache_read_request(cache_read_request),
    .cache_hit_vector  (cache_hit_vector),
    .bus_hit_vector    (bus_hit_vector),
    .evict_candidate   (evict_candidate),
    .req_msg_valid     (req_msg_valid),
    .req_msg_src       (req_msg_src),
    .req_msg_addr      (req_msg_addr),
    .req_msg_cmd       (req_msg_cmd),
    .resp_msg_valid    (resp_msg_valid),
    .resp_msg_src      (resp_msg_src),
    .resp_msg_dst      (resp_msg_dst),
    .resp_msg_way      (resp_msg_way),
    .resp_msg_kind     (resp_msg_kind),
    .resp_msg_data     (resp_msg_data),
    .invalidate_req    (invalidate_req),
    .dfp_rdata         (dfp_rdata),
    .dfp_resp          (dfp_resp),
    .req_bus_busy      (req_bus_busy),
    .invalidate_resp   (invalidate_resp),
    .issue_gets        (issue_gets),
    .own_gets_seen     (own_gets_seen),
    .lsif              (lsif.ctrl),
    .snp               (snp.ctrl)
  );

  line_state_array #(.WAYS(WAYS), .SETS(SETS)) array_i (
    .clk (clk),
    .rst (rst),
    .lsif(lsif.array)
  );

  bus_req_issuer #(.CACHE_ID(CACHE_ID)) issuer_i (
    .clk          (clk),
    .rst          (rst),
    .issue_gets   (issue_gets),
    .own_gets_seen(own_gets_seen),
    .dfp_addr     (dfp_addr),
    .req_bus_req  (req_bus_req),
    .req_tx_src   (req_tx_src),
    .req_tx_addr  (req_tx_addr),
    .req_tx_cmd   (req_tx_cmd)
  );

  snoop_responder #(.WAYS(WAYS)) responder_i (
    .clk         (clk),
    .rst         (rst),
    .snp         (snp.resp),
    .req_msg_addr(req_msg_addr),
    .bus_rdata   (bus_rdata),
    .resp_bus_req(resp_bus_req),
    .resp_tx_dst (resp_tx_dst),
    .resp_tx_way (resp_tx_way),
    .resp_tx_mem (resp_tx_mem),
    .resp_tx_addr(resp_tx_addr),
    .resp_tx_data(resp_tx_data),
    .resp_tx_kind(resp_tx_kind)
  );

endmodule

//--- rtl/coherence_ctrl.sv
`timescale 1ns/1ps

module coherence_ctrl
  import coh_pkg::*;
#(
  parameter int WAYS     = 4,
  parameter int SETS     = 16,
  parameter int CACHE_ID = 0,
  parameter int MEM_ID   = 15
) (
  input  logic                    clk,
  input  logic                    rst,
  input  addr_t                   dfp_addr,
  input  logic                    dfp_read,
  input  logic                    cache_read_request,
  input  logic [WAYS-1:0]         cache_hit_vector,
  input  logic [WAYS-1:0]         bus_hit_vector,
  input  logic [WAYS-1:0]         evict_candidate,
  input  logic                    req_msg_valid,
  input  cache_id_t               req_msg_src,
  input  addr_t                   req_msg_addr,
  input  bus_cmd_t                req_msg_cmd,
  input  logic                    resp_msg_valid,
  input  cache_id_t               resp_msg_src,
  input  cache_id_t               resp_msg_dst,
  input  logic [$clog2(WAYS)-1:0] resp_msg_way,
  input  resp_kind_t              resp_msg_kind,
  input  line_t                   resp_msg_data,
  input  logic                    invalidate_req,
  output line_t                   dfp_rdata,
  output logic                    dfp_resp,
  output logic                    req_bus_busy,
  output logic                    invalidate_resp,
  output logic                    issue_gets,
  output logic                    own_gets_seen,
  line_state_if.ctrl              lsif,
  snoop_if.ctrl                   snp
);

  localparam int        WAY_BITS = $clog2(WAYS);
  localparam int        IDX_BITS = $clog2(SETS);
  localparam cache_id_t MY_ID    = cache_id_t'(CACHE_ID);
  localparam cache_id_t MEM_NODE = cache_id_t'(MEM_ID);

  logic                req_ev, resp_ev, inv_ev, cpu_ev;
  logic                own_resp;
  logic [IDX_BITS-1:0] cur_index;
  logic [WAY_BITS-1:0] hit_way, bus_way, evict_way;
  line_state_t         hit_st, bus_st, evict_st, miss_st, snp_st;
  logic                fill, hit_resp, inv_hit, busy_set, busy_clr;

  // Outstanding miss and snoop bookkeeping
  logic                miss_active;
  logic [IDX_BITS-1:0] miss_index, snp_index;
  logic [WAY_BITS-1:0] miss_way, snp_way;

  // Lowest set bit of a way vector
  function automatic logic [WAY_BITS-1:0] first_way(input logic [WAYS-1:0] vec);
    logic [WAY_BITS-1:0] idx;
    idx = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (vec[w]) begin
        idx = WAY_BITS'(w);
      end
    end
    return idx;
  endfunction

  // One event per cycle: request bus, response bus, back invalidation, processor
  assign req_ev   = req_msg_valid;
  assign resp_ev  = !req_msg_valid && resp_msg_valid;
  assign inv_ev   = !req_msg_valid && !resp_msg_valid && invalidate_req;
  assign cpu_ev   = !req_msg_valid && !resp_msg_valid && !invalidate_req && cache_read_request;
  assign own_resp = (resp_msg_src == MY_ID);

  always_comb begin
    cur_index = dfp_addr[IDX_BITS-1:0];
    if (req_ev) begin
      cur_index = req_msg_addr[IDX_BITS-1:0];
    end else if (resp_ev) begin
      cur_index = own_resp ? snp_index : miss_index;
    end
  end

  assign lsif.rd_index = cur_index;
  assign lsif.wr_index = cur_index;

  assign hit_way   = first_way(cache_hit_vector);
  assign bus_way   = first_way(bus_hit_vector);
  assign evict_way = first_way(evict_candidate);
  assign hit_st    = lsif.rd_states[hit_way];
  assign bus_st    = lsif.rd_states[bus_way];
  assign evict_st  = lsif.rd_states[evict_way];
  assign miss_st   = lsif.rd_states[miss_way];
  assign snp_st    = lsif.rd_states[snp_way];

  // Snoop response fields follow the request on the bus
  assign snp.dest     = req_msg_src;
  assign snp.mem_flag = (req_msg_cmd == GETS);
  assign snp.way      = bus_way;

  always_comb begin
    lsif.wr_en    = 1'b0;
    lsif.wr_way   = '0;
    lsif.wr_state = ST_I;
    issue_gets    = 1'b0;
    own_gets_seen = 1'b0;
    snp.send      = 1'b0;
    snp.retire    = 1'b0;
    fill          = 1'b0;
    hit_resp      = 1'b0;
    inv_hit       = 1'b0;
    busy_set      = 1'b0;
    busy_clr      = 1'b0;

    if (req_ev) begin
      if (req_msg_src == MY_ID) begin
        if (req_msg_cmd == GETS && miss_st == ST_ISAD) begin
          own_gets_seen = 1'b1;
          busy_set      = 1'b1;
          lsif.wr_en    = 1'b1;
          lsif.wr_way   = miss_way;
          lsif.wr_state = ST_ISD;
        end
      end else if (req_msg_src != MEM_NODE && |bus_hit_vector) begin
        // Memory never issues requests
        case (bus_st)
          ST_E: begin
            if (req_msg_cmd == GETS || req_msg_cmd == GETM) begin
              snp.send      = 1'b1;
              busy_set      = 1'b1;
              lsif.wr_en    = 1'b1;
              lsif.wr_way   = bus_way;
              lsif.wr_state = (req_msg_cmd == GETS) ? ST_SRD : ST_IRD;
            end
          end
          ST_S: begin
            if (req_msg_cmd == GETM) begin
              lsif.wr_en    = 1'b1;
              lsif.wr_way   = bus_way;
              lsif.wr_state = ST_I;
            end
          end
          default: begin
          end
        endcase
      end
    end else if (resp_ev) begin
      if (own_resp) begin
        if (resp_msg_way == snp_way && (snp_st == ST_SRD || snp_st == ST_IRD)) begin
          snp.retire    = 1'b1;
          busy_clr      = 1'b1;
          lsif.wr_en    = 1'b1;
          lsif.wr_way   = snp_way;
          lsif.wr_state = (snp_st == ST_SRD) ? ST_S : ST_I;
        end
      end else if (resp_msg_dst == MY_ID && miss_active && miss_st == ST_ISD) begin
        fill          = 1'b1;
        busy_clr      = 1'b1;
        lsif.wr_en    = 1'b1;
        lsif.wr_way   = miss_way;
        lsif.wr_state = (resp_msg_kind == EXCLUSIVE) ? ST_E : ST_S;
      end
    end else if (inv_ev) begin
      if (|cache_hit_vector && (hit_st == ST_S || hit_st == ST_E)) begin
        inv_hit       = 1'b1;
        lsif.wr_en    = 1'b1;
        lsif.wr_way   = hit_way;
        lsif.wr_state = ST_I;
      end
    end else if (cpu_ev) begin
      if (|cache_hit_vector && (hit_st == ST_S || hit_st == ST_E)) begin
        hit_resp = 1'b1;
      end else if (dfp_read && |evict_candidate && evict_st == ST_I &&
                   !miss_active && !req_bus_busy) begin
        // One miss at a time, and none while the bus is held
        issue_gets    = 1'b1;
        lsif.wr_en    = 1'b1;
        lsif.wr_way   = evict_way;
        lsif.wr_state = ST_ISAD;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dfp_resp        <= 1'b0;
      dfp_rdata       <= '0;
      invalidate_resp <= 1'b0;
      req_bus_busy    <= 1'b0;
      miss_active     <= 1'b0;
    end else begin
      dfp_resp        <= fill | hit_resp;
      invalidate_resp <= inv_hit;
      if (fill) begin
        dfp_rdata <= resp_msg_data;
      end
      if (busy_set) begin
        req_bus_busy <= 1'b1;
      end else if (busy_clr) begin
        req_bus_busy <= 1'b0;
      end
      if (issue_gets) begin
        miss_active <= 1'b1;
      end else if (fill) begin
        miss_active <= 1'b0;
      end
    end
  end

  // Where the pending miss and snoop live in the state array
  always_ff @(posedge clk) begin
    if (issue_gets) begin
      miss_index <= dfp_addr[IDX_BITS-1:0];
      miss_way   <= evict_way;
    end
    if (snp.send) begin
      snp_index <= req_msg_addr[IDX_BITS-1:0];
      snp_way   <= bus_way;
    end
  end

endmodule

//--- rtl/snoop_responder.sv
`timescale 1ns/1ps

module snoop_responder
  import coh_pkg::*;
#(
  parameter int WAYS = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  snoop_if.resp                   snp,
  input  addr_t                   req_msg_addr,
  input  line_t                   bus_rdata,
  output logic                    resp_bus_req,
  output cache_id_t               resp_tx_dst,
  output logic [$clog2(WAYS)-1:0] resp_tx_way,
  output logic                    resp_tx_mem,
  output addr_t                   resp_tx_addr,
  output line_t                   resp_tx_data,
  output resp_kind_t              resp_tx_kind
);

  // Data response for a snooped E line, held until it appears on the bus
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_bus_req <= 1'b0;
      resp_tx_dst  <= '0;
      resp_tx_way  <= '0;
      resp_tx_mem  <= 1'b0;
      resp_tx_addr <= '0;
      resp_tx_data <= '0;
      resp_tx_kind <= DATA;
    end else if (snp.send) begin
      resp_bus_req <= 1'b1;
      resp_tx_dst  <= snp.dest;
      resp_tx_way  <= snp.way;
      resp_tx_mem  <= snp.mem_flag;
      resp_tx_addr <= req_msg_addr;
      resp_tx_data <= bus_rdata;
      resp_tx_kind <= DATA;
    end else if (snp.retire) begin
      resp_bus_req <= 1'b0;
      resp_tx_dst  <= '0;
      resp_tx_way  <= '0;
      resp_tx_mem  <= 1'b0;
      resp_tx_addr <= '0;
      resp_tx_data <= '0;
      resp_tx_kind <= DATA;
    end
  end

endmodule

//--- rtl/bus_req_issuer.sv
`timescale 1ns/1ps

module bus_req_issuer
  import coh_pkg::*;
#(
  parameter int CACHE_ID = 0
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      issue_gets,
  input  logic      own_gets_seen,
  input  addr_t     dfp_addr,
  output logic      req_bus_req,
  output cache_id_t req_tx_src,
  output addr_t     req_tx_addr,
  output bus_cmd_t  req_tx_cmd
);

  // GetS stays on the outputs until the bus shows it back to us
  always_ff @(posedge clk) begin
    if (rst) begin
      req_bus_req <= 1'b0;
      req_tx_src  <= '0;
      req_tx_addr <= '0;
      req_tx_cmd  <= NONE;
    end else if (issue_gets) begin
      req_bus_req <= 1'b1;
      req_tx_src  <= cache_id_t'(CACHE_ID);
      req_tx_addr <= dfp_addr;
      req_tx_cmd  <= GETS;
    end else if (own_gets_seen) begin
      req_bus_req <= 1'b0;
      req_tx_src  <= '0;
      req_tx_addr <= '0;
      req_tx_cmd  <= NONE;
    end
  end

endmodule

//--- rtl/line_state_array.sv
`timescale 1ns/1ps

module line_state_array
  import coh_pkg::*;
#(
  parameter int WAYS = 4,
  parameter int SETS = 16
) (
  input  logic        clk,
  input  logic        rst,
  line_state_if.array lsif
);

  line_state_t states [WAYS][SETS];

  // All ways at the requested set
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      lsif.rd_states[w] = states[w][lsif.rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
          states[w][s] <= ST_I;
        end
      end
    end else if (lsif.wr_en) begin
      states[lsif.wr_way][lsif.wr_index] <= lsif.wr_state;
    end
  end

endmodule

//--- rtl/snoop_if.sv
`timescale 1ns/1ps

interface snoop_if
  import coh_pkg::*;
#(
  parameter int WAYS = 4
);

  // Single-cycle pulse with the response fields alongside
  logic                    send;
  cache_id_t               dest;
  logic                    mem_flag;
  logic [$clog2(WAYS)-1:0] way;

  // Own response has been seen on the response bus
  logic                    retire;

  modport ctrl (output send, dest, mem_flag, way, retire);
  modport resp (input send, dest, mem_flag, way, retire);

endinterface

//--- rtl/line_state_if.sv
`timescale 1ns/1ps

interface line_state_if
  import coh_pkg::*;
#(
  parameter int WAYS = 4,
  parameter int SETS = 16
);

  logic [$clog2(SETS)-1:0] rd_index;
  line_state_t [WAYS-1:0]  rd_states;

  // One write per cycle, visible after the next edge
  logic                    wr_en;
  logic [$clog2(WAYS)-1:0] wr_way;
  logic [$clog2(SETS)-1:0] wr_index;
  line_state_t             wr_state;

  modport ctrl (output rd_index, input rd_states, output wr_en, wr_way, wr_index, wr_state);
  modport array (input rd_index, output rd_states, input wr_en, wr_way, wr_index, wr_state);

endinterface

//--- rtl/coh_pkg.sv
package coh_pkg;

  // Line geometry
  localparam int ADDR_BITS = 32;
  localparam int LINE_BITS = 256;
  localparam int ID_BITS   = 4;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [LINE_BITS-1:0] line_t;

  // Node number on both buses, memory included
  typedef logic [ID_BITS-1:0] cache_id_t;

  // Stable states S and E plus the transient ones a read-only cache can reach
  typedef enum logic [2:0] {
    ST_I,
    ST_ISAD,
    ST_ISD,
    ST_S,
    ST_E,
    ST_SRD,
    ST_IRD
  } line_state_t;

  // Request bus commands
  typedef enum logic [1:0] {
    NONE,
    GETS,
    GETM
  } bus_cmd_t;

  // Response bus message kinds
  typedef enum logic {
    DATA,
    EXCLUSIVE
  } resp_kind_t;

endpackage
